// ==== design/cacc_cfg.svh ====
`ifndef CACC_CFG_SVH
`define CACC_CFG_SVH

// bus word and vector element width.
`define CACC_DATA_W 32

// byte address width on both buses.
`define CACC_ADDR_W 32

// element count.
`define CACC_LEN_W 16

// dot product accumulator.
`define CACC_ACC_W 64

`define CACC_CSR_AW 3 // csr word index.

`endif

// ==== design/cacc_csr_pkg.sv ====
`include "cacc_cfg.svh"

package cacc_csr_pkg;

  // host visible register map, word indices.
  typedef enum logic [`CACC_CSR_AW-1:0] {
    CSR_ADDR_A    = 0,
    CSR_ADDR_B    = 1,
    CSR_LEN       = 2,
    CSR_START     = 3,
    CSR_STATUS    = 4,
    CSR_RESULT_LO = 5,
    CSR_RESULT_HI = 6
  } csr_addr_e;

  // command handed to the engine on start.
  typedef struct packed {
    logic [`CACC_ADDR_W-1:0] addr_a; // first operand base.
    logic [`CACC_ADDR_W-1:0] addr_b; // second operand base.
    logic [`CACC_LEN_W-1:0]  len;    // elements.
  } vdp_cmd_s;

  // engine state as seen by the host.
  typedef struct packed {
    logic                          busy;
    logic                          done;
    logic signed [`CACC_ACC_W-1:0] result;
  } vdp_status_s;

endpackage

// ==== design/cacc_mem_pkg.sv ====
`include "cacc_cfg.svh"

package cacc_mem_pkg;

  // wishbone classic, master to slave.
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`CACC_ADDR_W-1:0]   adr;
    logic [`CACC_DATA_W-1:0]   dat;
    logic [`CACC_DATA_W/8-1:0] sel;
  } wb_m2s_s;

  // wishbone classic, slave to master.
  typedef struct packed {
    logic                    ack;
    logic [`CACC_DATA_W-1:0] dat;
  } wb_s2m_s;

  // engine read request, valid/ready.
  typedef struct packed {
    logic                    valid;
    logic [`CACC_ADDR_W-1:0] addr;
  } mem_req_s;

  // read data back to the engine, in order.
  typedef struct packed {
    logic                    valid; // one cycle per request.
    logic [`CACC_DATA_W-1:0] data;
  } mem_resp_s;

endpackage

// ==== design/cacc_io_slave.sv ====
`timescale 1ns/10ps
`include "cacc_cfg.svh"

module cacc_io_slave (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  cacc_mem_pkg::wb_m2s_s     host_wb_i,
  output cacc_mem_pkg::wb_s2m_s     host_wb_o,
  input  cacc_csr_pkg::vdp_status_s status_i,
  output cacc_csr_pkg::vdp_cmd_s    cmd_o,
  output logic                      start_o
);

  cacc_csr_pkg::csr_addr_e csr_addr;
  cacc_csr_pkg::vdp_cmd_s  cmd_q;
  logic                    req;
  logic                    ack_q;
  logic                    start_q;
  logic [`CACC_DATA_W-1:0] rdata_d;
  logic [`CACC_DATA_W-1:0] rdata_q;

  assign csr_addr = cacc_csr_pkg::csr_addr_e'(host_wb_i.adr[`CACC_CSR_AW+1:2]);
  assign req      = host_wb_i.cyc && host_wb_i.stb && !ack_q; // one ack, then a gap.

  always_comb
  begin
    case (csr_addr)
      cacc_csr_pkg::CSR_ADDR_A:    rdata_d = cmd_q.addr_a;
      cacc_csr_pkg::CSR_ADDR_B:    rdata_d = cmd_q.addr_b;
      cacc_csr_pkg::CSR_LEN:       rdata_d = {{(`CACC_DATA_W-`CACC_LEN_W){1'b0}}, cmd_q.len};
      cacc_csr_pkg::CSR_STATUS:    rdata_d = {{(`CACC_DATA_W-2){1'b0}}, status_i.done,
                                              status_i.busy};
      cacc_csr_pkg::CSR_RESULT_LO: rdata_d = status_i.result[`CACC_DATA_W-1:0];
      cacc_csr_pkg::CSR_RESULT_HI: rdata_d = status_i.result[`CACC_ACC_W-1:`CACC_DATA_W];
      default:                     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
      cmd_q   <= '0;
    end
    else
    begin
      ack_q   <= req;
      start_q <= req && host_wb_i.we && (csr_addr == cacc_csr_pkg::CSR_START)
                 && !status_i.busy; // late starts are acked and dropped.
      if (req && host_wb_i.we)
      begin
        case (csr_addr)
          cacc_csr_pkg::CSR_ADDR_A: cmd_q.addr_a <= host_wb_i.dat;
          cacc_csr_pkg::CSR_ADDR_B: cmd_q.addr_b <= host_wb_i.dat;
          cacc_csr_pkg::CSR_LEN:    cmd_q.len    <= host_wb_i.dat[`CACC_LEN_W-1:0];
          default:                  ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (req && !host_wb_i.we)
      rdata_q <= rdata_d; // returned with the ack.
  end

  assign host_wb_o.ack = ack_q;
  assign host_wb_o.dat = rdata_q;
  assign cmd_o         = cmd_q;
  assign start_o       = start_q;

  // a start pulse is always taken by an idle engine.
  start_taken: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_o |=> status_i.busy);

endmodule

// ==== design/cacc_vdp_engine.sv ====
`timescale 1ns/10ps
`include "cacc_cfg.svh"

module cacc_vdp_engine (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  cacc_csr_pkg::vdp_cmd_s    cmd_i,
  input  logic                      start_i,
  output cacc_csr_pkg::vdp_status_s status_o,
  output logic                      irq_o,
  output cacc_mem_pkg::mem_req_s    mem_req_o,
  input  logic                      mem_req_ready_i,
  input  cacc_mem_pkg::mem_resp_s   mem_resp_i
);

  typedef enum logic [2:0] {
    IDLE,
    REQ_A,
    REQ_B,
    WAIT,
    DONE
  } vdp_state_e;

  vdp_state_e                    state_q;
  logic                          busy_q;
  logic                          done_q;
  logic                          start_ok;
  logic                          req_fire;
  logic [`CACC_ADDR_W-1:0]       ptr_a_q;
  logic [`CACC_ADDR_W-1:0]       ptr_b_q;
  logic [`CACC_LEN_W-1:0]        len_q;
  logic [`CACC_LEN_W-1:0]        cnt_q;
  logic [`CACC_LEN_W-1:0]        cnt_nxt;
  logic [`CACC_DATA_W-1:0]       a_q;
  logic signed [`CACC_ACC_W-1:0] a_ext;
  logic signed [`CACC_ACC_W-1:0] b_ext;
  logic signed [`CACC_ACC_W-1:0] prod_q;
  logic                          mac_v_q;
  logic signed [`CACC_ACC_W-1:0] acc_q;

  assign start_ok = start_i && (state_q == IDLE);
  assign req_fire = mem_req_o.valid && mem_req_ready_i;
  assign cnt_nxt  = cnt_q + 1'b1;

  assign a_ext = {{(`CACC_ACC_W-`CACC_DATA_W){a_q[`CACC_DATA_W-1]}}, a_q};
  assign b_ext = {{(`CACC_ACC_W-`CACC_DATA_W){mem_resp_i.data[`CACC_DATA_W-1]}},
                  mem_resp_i.data};

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= IDLE;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      cnt_q   <= '0;
      mac_v_q <= 1'b0;
      acc_q   <= '0;
    end
    else
    begin
      mac_v_q <= (state_q == WAIT) && mem_resp_i.valid;
      if (start_ok)
        acc_q <= '0;
      else if (mac_v_q)
        acc_q <= acc_q + prod_q; // second half of the mac.

      case (state_q)
        IDLE:
          if (start_ok)
          begin
            busy_q  <= 1'b1;
            done_q  <= 1'b0;
            cnt_q   <= '0;
            state_q <= (cmd_i.len == '0) ? DONE : REQ_A;
          end
        REQ_A:
          if (req_fire)
            state_q <= REQ_B;
        REQ_B:
          if (req_fire)
            state_q <= WAIT; // a word is back by now.
        WAIT:
          if (mem_resp_i.valid)
          begin
            cnt_q   <= cnt_nxt;
            state_q <= (cnt_nxt == len_q) ? DONE : REQ_A; // next reads overlap the add.
          end
        DONE:
        begin
          busy_q  <= 1'b0;
          done_q  <= 1'b1;
          state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // operand pointers and data path.
  always_ff @(posedge clk_i)
  begin
    if (start_ok)
    begin
      ptr_a_q <= cmd_i.addr_a;
      ptr_b_q <= cmd_i.addr_b;
      len_q   <= cmd_i.len;
    end
    else if (req_fire)
    begin
      if (state_q == REQ_A)
        ptr_a_q <= ptr_a_q + 'd4;
      else
        ptr_b_q <= ptr_b_q + 'd4;
    end
    if ((state_q == REQ_B) && mem_resp_i.valid)
      a_q <= mem_resp_i.data;
    if ((state_q == WAIT) && mem_resp_i.valid)
      prod_q <= a_ext * b_ext;
  end

  assign mem_req_o.valid = (state_q == REQ_A) || (state_q == REQ_B);
  assign mem_req_o.addr  = (state_q == REQ_A) ? ptr_a_q : ptr_b_q;

  assign status_o.busy   = busy_q;
  assign status_o.done   = done_q;
  assign status_o.result = acc_q;
  assign irq_o           = done_q;

  no_resp_in_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == IDLE) |-> !mem_resp_i.valid);

endmodule

// ==== design/cacc_mem_master.sv ====
`timescale 1ns/10ps
`include "cacc_cfg.svh"

module cacc_mem_master (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  cacc_mem_pkg::mem_req_s  mem_req_i,
  output logic                    mem_req_ready_o,
  output cacc_mem_pkg::mem_resp_s mem_resp_o,
  output cacc_mem_pkg::wb_m2s_s   mem_wb_o,
  input  cacc_mem_pkg::wb_s2m_s   mem_wb_i
);

  logic                    cyc_q;
  logic                    rvalid_q;
  logic                    accept;
  logic                    done;
  logic [`CACC_ADDR_W-1:0] adr_q;
  logic [`CACC_DATA_W-1:0] rdata_q;

  assign mem_req_ready_o = !cyc_q; // one cycle open at a time.
  assign accept          = mem_req_i.valid && mem_req_ready_o;
  assign done            = cyc_q && mem_wb_i.ack;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cyc_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      rvalid_q <= done;
      if (done)
        cyc_q <= 1'b0;
      else if (accept)
        cyc_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      adr_q <= mem_req_i.addr;
    if (done)
      rdata_q <= mem_wb_i.dat;
  end

  // read only, full word.
  assign mem_wb_o.cyc = cyc_q;
  assign mem_wb_o.stb = cyc_q;
  assign mem_wb_o.we  = 1'b0;
  assign mem_wb_o.adr = adr_q;
  assign mem_wb_o.dat = '0;
  assign mem_wb_o.sel = '1;

  assign mem_resp_o.valid = rvalid_q;
  assign mem_resp_o.data  = rdata_q;

  req_held_until_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_req_i.valid && !mem_req_ready_o) |=> (mem_req_i.valid && $stable(mem_req_i.addr)));

endmodule

// ==== design/cacc_tile.sv ====
`timescale 1ns/10ps

module cacc_tile (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  cacc_mem_pkg::wb_m2s_s host_wb_i,
  output cacc_mem_pkg::wb_s2m_s host_wb_o,
  output cacc_mem_pkg::wb_m2s_s mem_wb_o,
  input  cacc_mem_pkg::wb_s2m_s mem_wb_i,
  output logic                  irq_o
);

  cacc_csr_pkg::vdp_cmd_s    cmd;
  cacc_csr_pkg::vdp_status_s status;
  logic                      start;
  cacc_mem_pkg::mem_req_s    mem_req;
  logic                      mem_req_ready;
  cacc_mem_pkg::mem_resp_s   mem_resp;

  // host command front end.
  cacc_io_slave u_io_slave (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .host_wb_i (host_wb_i),
    .host_wb_o (host_wb_o),
    .status_i  (status),
    .cmd_o     (cmd),
    .start_o   (start)
  );

  cacc_vdp_engine u_vdp_engine (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cmd_i           (cmd),
    .start_i         (start),
    .status_o        (status),
    .irq_o           (irq_o),
    .mem_req_o       (mem_req),
    .mem_req_ready_i (mem_req_ready),
    .mem_resp_i      (mem_resp)
  );

  // memory side link.
  cacc_mem_master u_mem_master (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .mem_req_i       (mem_req),
    .mem_req_ready_o (mem_req_ready),
    .mem_resp_o      (mem_resp),
    .mem_wb_o        (mem_wb_o),
    .mem_wb_i        (mem_wb_i)
  );

endmodule

// ==== tests/cacc_mem_model.sv ====
`timescale 1ns/10ps
`include "cacc_cfg.svh"

module cacc_mem_model #(
  parameter int DEPTH = 1024,
  parameter int LAT_N = 64
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  cacc_mem_pkg::wb_m2s_s wb_i,
  output cacc_mem_pkg::wb_s2m_s wb_o
);

  localparam int AW = $clog2(DEPTH);

  logic [`CACC_DATA_W-1:0] mem [DEPTH];
  logic [1:0]              lat_tbl [LAT_N]; // ack delays, loaded by the testbench.
  cacc_mem_pkg::wb_s2m_s   rsp_q = '0;
  int                      wait_cnt = -1;
  int                      lat_idx = 0;

  initial
  begin
    for (int i = 0; i < DEPTH; i++)
      mem[i] = 32'hc0de_0000 ^ i; // marks unloaded words.
  end

  always @(negedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rsp_q.ack <= 1'b0;
      wait_cnt = -1;
    end
    else if (rsp_q.ack)
    begin
      rsp_q.ack <= 1'b0; // single cycle ack.
      wait_cnt = -1;
    end
    else if (wb_i.cyc && wb_i.stb)
    begin
      if (wait_cnt < 0)
      begin
        wait_cnt = lat_tbl[lat_idx];
        lat_idx  = (lat_idx + 1) % LAT_N;
      end
      if (wait_cnt == 0)
      begin
        rsp_q.ack <= 1'b1;
        rsp_q.dat <= mem[wb_i.adr[AW+1:2]];
      end
      else
        wait_cnt = wait_cnt - 1;
    end
  end

  assign wb_o = rsp_q;

endmodule

// ==== tests/cacc_tile_tb.sv ====
`timescale 1ns/10ps
`include "cacc_cfg.svh"

module cacc_tile_tb;

  localparam int          ACK_LIMIT = 16;
  localparam logic [31:0] SEED      = 32'h566e_117d;
  // elements per test: readback, basic, signed, zero, busy, restart.
  localparam int WATCHDOG_CYCLES = 40 * (0 + 8 + 16 + 0 + 12 + 16) + 200 * 6;

  logic                  clk = 1'b0;
  logic                  rst_n = 1'b0;
  logic                  irq;
  cacc_mem_pkg::wb_m2s_s host_wb = '0;
  cacc_mem_pkg::wb_s2m_s host_rsp;
  cacc_mem_pkg::wb_m2s_s mem_req;
  cacc_mem_pkg::wb_s2m_s mem_rsp;
  int                    err_cnt = 0;
  int                    check_cnt = 0;
  int                    test_cnt = 0;

  cacc_tile uut (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .host_wb_i (host_wb),
    .host_wb_o (host_rsp),
    .mem_wb_o  (mem_req),
    .mem_wb_i  (mem_rsp),
    .irq_o     (irq)
  );

  cacc_mem_model mem_model (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .wb_i    (mem_req),
    .wb_o    (mem_rsp)
  );

  initial
  begin
    forever #50 clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * 100);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_cnt++;
    assert (got === exp)
    else
    begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    check_cnt++;
    assert (cond === 1'b1)
    else
    begin
      $display("%s", msg);
      err_cnt++;
    end
  endtask

  // memory side cycles are full word reads.
  always @(negedge clk)
  begin
    if (rst_n && mem_req.cyc)
    begin
      check_value("mem_wb_o.stb", mem_req.stb, 1'b1);
      check_value("mem_wb_o.we", mem_req.we, 1'b0);
      check_value("mem_wb_o.sel", mem_req.sel, {(`CACC_DATA_W/8){1'b1}});
    end
  end

  // one classic cycle, held until ack and released on the same falling edge.
  task automatic bus_cycle(input cacc_csr_pkg::csr_addr_e csr, input logic we,
                           input logic [`CACC_DATA_W-1:0] wdata,
                           output logic [`CACC_DATA_W-1:0] rdata);
    int waited;
    waited = 0;
    @(negedge clk);
    host_wb.cyc = 1'b1;
    host_wb.stb = 1'b1;
    host_wb.we  = we;
    host_wb.adr = 32'(csr) << 2;
    host_wb.dat = wdata;
    host_wb.sel = '1;
    do
    begin
      @(negedge clk);
      waited++;
    end
    while (!host_rsp.ack && waited < ACK_LIMIT);
    check_true(host_rsp.ack, "host access got no ack");
    rdata   = host_rsp.dat;
    host_wb = '0;
  endtask

  task automatic wb_write(input cacc_csr_pkg::csr_addr_e csr,
                          input logic [`CACC_DATA_W-1:0] data);
    logic [`CACC_DATA_W-1:0] unused;
    bus_cycle(csr, 1'b1, data, unused);
  endtask

  task automatic wb_read(input cacc_csr_pkg::csr_addr_e csr,
                         output logic [`CACC_DATA_W-1:0] data);
    bus_cycle(csr, 1'b0, '0, data);
  endtask

  // signed 64-bit sum of products over the model's words.
  function automatic longint expected_dot(input int a_word, input int b_word, input int len);
    longint acc;
    int     a;
    int     b;
    acc = 0;
    for (int i = 0; i < len; i++)
    begin
      a   = mem_model.mem[a_word + i];
      b   = mem_model.mem[b_word + i];
      acc += longint'(a) * longint'(b);
    end
    return acc;
  endfunction

  task automatic load_random(input int word, input int len);
    for (int i = 0; i < len; i++)
      mem_model.mem[word + i] = $urandom;
  endtask

  task automatic start_dot(input int a_word, input int b_word, input int len);
    wb_write(cacc_csr_pkg::CSR_ADDR_A, a_word * 4);
    wb_write(cacc_csr_pkg::CSR_ADDR_B, b_word * 4);
    wb_write(cacc_csr_pkg::CSR_LEN, len);
    wb_write(cacc_csr_pkg::CSR_START, 32'h1);
  endtask

  task automatic wait_done(input int len, output logic [31:0] st);
    int polls;
    polls = 0;
    do
    begin
      wb_read(cacc_csr_pkg::CSR_STATUS, st);
      polls++;
    end
    while (!st[1] && polls < 20 * len + 20);
    check_true(st[1], "engine never reported done");
  endtask

  task automatic read_result(output logic [63:0] res);
    logic [31:0] lo;
    logic [31:0] hi;
    wb_read(cacc_csr_pkg::CSR_RESULT_LO, lo);
    wb_read(cacc_csr_pkg::CSR_RESULT_HI, hi);
    res = {hi, lo};
  endtask

  task automatic report_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, err_cnt - err_before);
  endtask

  task automatic test_readback();
    int          err0;
    logic [31:0] rd;
    err0 = err_cnt;
    wb_write(cacc_csr_pkg::CSR_ADDR_A, 32'h1234_5670);
    wb_write(cacc_csr_pkg::CSR_ADDR_B, 32'h0bad_cafc);
    wb_write(cacc_csr_pkg::CSR_LEN, 32'hffff_0123);
    wb_read(cacc_csr_pkg::CSR_ADDR_A, rd);
    check_value("addr_a", rd, 32'h1234_5670);
    wb_read(cacc_csr_pkg::CSR_ADDR_B, rd);
    check_value("addr_b", rd, 32'h0bad_cafc);
    wb_read(cacc_csr_pkg::CSR_LEN, rd);
    check_value("len", rd, 32'h0000_0123); // only 16 bits kept.
    wb_read(cacc_csr_pkg::CSR_STATUS, rd);
    check_value("status", rd, 32'h0);
    report_test("register readback", err0);
  endtask

  task automatic test_basic();
    int          err0;
    logic [31:0] st;
    logic [63:0] res;
    longint      exp;
    err0 = err_cnt;
    for (int i = 0; i < 8; i++)
    begin
      mem_model.mem[i]      = i + 1;
      mem_model.mem[64 + i] = 10 - 3 * i; // crosses zero.
    end
    exp = expected_dot(0, 64, 8);
    start_dot(0, 64, 8);
    wait_done(8, st);
    check_true(irq, "irq_o low after done");
    check_value("status.busy", st[0], 1'b0);
    read_result(res);
    check_value("result", res, exp);
    report_test("basic dot product", err0);
  endtask

  task automatic test_signed();
    int          err0;
    logic [31:0] st;
    logic [63:0] res;
    err0 = err_cnt;
    load_random(128, 16);
    load_random(192, 16);
    mem_model.mem[128] = 32'h8000_0000;
    mem_model.mem[192] = 32'h8000_0000;
    mem_model.mem[129] = 32'h8000_0000;
    mem_model.mem[193] = 32'h7fff_ffff;
    mem_model.mem[130] = 32'hffff_ffff;
    mem_model.mem[194] = 32'hffff_fffe;
    start_dot(128, 192, 16);
    wait_done(16, st);
    read_result(res);
    check_value("result", res, expected_dot(128, 192, 16));
    report_test("signed and large values", err0);
  endtask

  task automatic test_zero_len();
    int          err0;
    logic [31:0] st;
    logic [63:0] res;
    err0 = err_cnt;
    start_dot(0, 64, 0);
    wait_done(0, st);
    check_true(irq, "irq_o low after zero length run");
    check_value("status.busy", st[0], 1'b0);
    read_result(res);
    check_value("result", res, 64'h0);
    report_test("zero length", err0);
  endtask

  task automatic test_start_busy();
    int          err0;
    logic [31:0] st;
    logic [63:0] res;
    longint      exp;
    err0 = err_cnt;
    load_random(256, 12);
    load_random(320, 12);
    exp = expected_dot(256, 320, 12);
    start_dot(256, 320, 12);
    wb_read(cacc_csr_pkg::CSR_STATUS, st);
    check_value("status.busy", st[0], 1'b1);
    wb_write(cacc_csr_pkg::CSR_ADDR_A, 32'h0);
    wb_write(cacc_csr_pkg::CSR_LEN, 32'h3);
    wb_write(cacc_csr_pkg::CSR_START, 32'h1); // dropped, engine is busy.
    wb_read(cacc_csr_pkg::CSR_STATUS, st);
    check_value("status.busy", st[0], 1'b1);
    check_value("status.done", st[1], 1'b0);
    wait_done(12, st);
    read_result(res);
    check_value("result", res, exp);
    repeat (10) @(negedge clk);
    wb_read(cacc_csr_pkg::CSR_STATUS, st);
    check_value("status.done", st[1], 1'b1);
    check_true(irq, "irq_o dropped without a new start");
    report_test("start while busy", err0);
  endtask

  task automatic test_restart();
    int          err0;
    logic [31:0] st;
    logic [63:0] res;
    err0 = err_cnt;
    load_random(384, 6);
    load_random(448, 6);
    load_random(512, 10);
    load_random(576, 10);
    start_dot(384, 448, 6);
    wait_done(6, st);
    read_result(res);
    check_value("first result", res, expected_dot(384, 448, 6));
    start_dot(512, 576, 10);
    wb_read(cacc_csr_pkg::CSR_STATUS, st);
    check_value("status.done", st[1], 1'b0);
    check_true(!irq, "irq_o still high after restart");
    wait_done(10, st);
    check_true(irq, "irq_o low after second run");
    read_result(res);
    check_value("second result", res, expected_dot(512, 576, 10));
    report_test("restart", err0);
  endtask

  initial
  begin
    void'($urandom(SEED));
    for (int i = 0; i < 64; i++)
      mem_model.lat_tbl[i] = $urandom % 4; // 0 to 3 wait cycles.
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    test_readback();
    test_basic();
    test_signed();
    test_zero_len();
    test_start_busy();
    test_restart();
    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+design
design/cacc_csr_pkg.sv
design/cacc_mem_pkg.sv
design/cacc_io_slave.sv
design/cacc_vdp_engine.sv
design/cacc_mem_master.sv
design/cacc_tile.sv
tests/cacc_mem_model.sv
tests/cacc_tile_tb.sv

// ==== Bender.yml ====
package:
  name: cacc_tile

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/cacc_csr_pkg.sv
      - design/cacc_mem_pkg.sv
      - design/cacc_io_slave.sv
      - design/cacc_vdp_engine.sv
      - design/cacc_mem_master.sv
      - design/cacc_tile.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/cacc_mem_model.sv
      - tests/cacc_tile_tb.sv
